// File: common/list_sel_pkg.sv
// ------------------------------------------------
// List-selection memory package
// Array geometry, power-gate timing and sequencer states
// ------------------------------------------------

package list_sel_pkg;

    // ------------------------------------------------
    // Register file geometry

    // Number of entries in the register file
    localparam int rf_depth = 4;

    // Address width for four entries
    localparam int rf_addr_w = 2;

    // Logical data width as seen by the list-selection engine
    localparam int rf_data_w = 35;

    // Physical macro width, the top bit is a spare that is written as zero
    localparam int rf_phys_w = 36;

    // ------------------------------------------------
    // Power-gate timing

    // Depth of the enable chain in rclk cycles
    // The acknowledge output trails the enable input by this many edges
    localparam int pwr_ack_dly = 3;

    // ------------------------------------------------
    // Power sequencer states

    // Off and sleep hold the supply gated, on is the only usable state
    typedef enum logic [2:0] {
        pwr_off,
        pwr_wake,
        pwr_on,
        pwr_isolate,
        pwr_sleep
    } pwr_state_e;

endpackage

// File: hw/mem_reset_sync_scan.sv
// ------------------------------------------------
// Memory reset synchronizer with scan bypass
// Async assert, two-flop sync release on rclk
// ------------------------------------------------

module mem_reset_sync_scan (
     input  logic rclk
    ,input  logic rst_n
    ,input  logic fscan_rstbypen
    ,input  logic fscan_byprst_b
    ,output logic rst_n_sync
);

    // Two synchronizer stages, bit 0 is the first flop
    logic [1:0] sync_q;

    // ------------------------------------------------
    // Synchronizer chain

    // Assertion reaches both stages at once without a clock
    // Release ripples a one through the chain, so the output rises
    // on the second rclk edge after rst_n goes high
    always_ff @(posedge rclk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], 1'b1};
        end
    end

    // ------------------------------------------------
    // Scan bypass

    // In test mode the reset comes straight from the scan pin
    // This keeps the downstream reset controllable while the two
    // synchronizer flops sit on the scan chain
    always_comb begin
        if (fscan_rstbypen) begin
            rst_n_sync = fscan_byprst_b;
        end else begin
            rst_n_sync = sync_q[1];
        end
    end

endmodule

// File: rf_4x36/rf_4x36_array.sv
// ------------------------------------------------
// Behavioral 4x36 two-port register file array
// Two clocks, enable chain, output isolation
// ------------------------------------------------

module rf_4x36_array import list_sel_pkg::*; (
     input  logic                 wclk
    ,input  logic                 we
    ,input  logic [rf_addr_w-1:0] waddr
    ,input  logic [rf_phys_w-1:0] wdata

    ,input  logic                 rclk
    ,input  logic                 re
    ,input  logic [rf_addr_w-1:0] raddr
    ,output logic [rf_phys_w-1:0] rdata

    ,input  logic                 ip_reset_b

    ,input  logic                 pgcb_isol_en
    ,input  logic                 pwr_enable_b_in
    ,output logic                 pwr_enable_b_out

    ,input  logic                 fscan_clkungate
);

    // Bit cells of the array
    logic [rf_phys_w-1:0] mem [rf_depth];

    // Read output register, the only state seen on rdata
    logic [rf_phys_w-1:0] rd_q;

    // Power switch enable chain, active low
    logic [pwr_ack_dly-1:0] pwr_chain_q;

    // Read clock enable after the scan ungate
    logic rd_capture;

    // ------------------------------------------------
    // Power switch enable chain

    // Each stage stands for one group of header switches
    // The enable ripples through one stage per rclk edge, and the
    // last stage is the acknowledge back to the power controller
    // The IP reset collapses the whole chain to the gated state
    always_ff @(posedge rclk or negedge ip_reset_b) begin
        if (!ip_reset_b) begin
            pwr_chain_q <= '1;
        end else begin
            pwr_chain_q <= {pwr_chain_q[pwr_ack_dly-2:0], pwr_enable_b_in};
        end
    end

    assign pwr_enable_b_out = pwr_chain_q[pwr_ack_dly-1];

    // ------------------------------------------------
    // Write port

    // With the supply gated the cells lose their charge, so the
    // contents go unknown and any write is dropped
    always_ff @(posedge wclk) begin
        if (pwr_enable_b_out) begin
            mem <= '{default: 'x};
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // ------------------------------------------------
    // Read port

    // Scan ungate forces the read clock on every edge
    assign rd_capture = re | fscan_clkungate;

    // One cycle read latency, data holds until the next capture
    always_ff @(posedge rclk or negedge ip_reset_b) begin
        if (!ip_reset_b) begin
            rd_q <= '0;
        end else if (rd_capture) begin
            rd_q <= mem[raddr];
        end
    end

    // ------------------------------------------------
    // Output isolation

    // Clamp to zero so an unpowered array never drives unknowns
    // into the always-on logic downstream
    always_comb begin
        if (pgcb_isol_en) begin
            rdata = '0;
        end else begin
            rdata = rd_q;
        end
    end

endmodule

// File: rf_4x36/list_sel_mem_rf_pg_4x35.sv
// ------------------------------------------------
// 4x35 power-gated register file wrapper
// Logical view of the 4x36 array with synced IP reset
// ------------------------------------------------

module list_sel_mem_rf_pg_4x35 import list_sel_pkg::*; (
     input  logic                 wclk
    ,input  logic                 arst_n
    ,input  logic                 we
    ,input  logic [rf_addr_w-1:0] waddr
    ,input  logic [rf_data_w-1:0] wdata

    ,input  logic                 rclk
    ,input  logic                 re
    ,input  logic [rf_addr_w-1:0] raddr

    ,output logic [rf_data_w-1:0] rdata

    // Power-gate controls from the sequencer
    ,input  logic                 pgcb_isol_en
    ,input  logic                 pwr_enable_b_in
    ,output logic                 pwr_enable_b_out

    // Scan controls
    ,input  logic                 fscan_byprst_b
    ,input  logic                 fscan_clkungate
    ,input  logic                 fscan_rstbypen
);

    // Full physical word returned by the array
    logic [rf_phys_w-1:0] rdata_phys;

    // Write word padded to the physical width
    logic [rf_phys_w-1:0] wdata_phys;

    // IP reset on the read clock
    logic ip_reset_b_sync;

    // ------------------------------------------------
    // IP reset synchronizer

    mem_reset_sync_scan u_ip_reset_b_sync (
         .rclk           (rclk)
        ,.rst_n          (arst_n)
        ,.fscan_rstbypen (fscan_rstbypen)
        ,.fscan_byprst_b (fscan_byprst_b)
        ,.rst_n_sync     (ip_reset_b_sync)
    );

    // ------------------------------------------------
    // Physical array

    // The spare column is unused and always written as zero
    assign wdata_phys = {1'b0, wdata};

    rf_4x36_array u_array (
         .wclk             (wclk)
        ,.we               (we)
        ,.waddr            (waddr)
        ,.wdata            (wdata_phys)
        ,.rclk             (rclk)
        ,.re               (re)
        ,.raddr            (raddr)
        ,.rdata            (rdata_phys)
        ,.ip_reset_b       (ip_reset_b_sync)
        ,.pgcb_isol_en     (pgcb_isol_en)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.pwr_enable_b_out (pwr_enable_b_out)
        ,.fscan_clkungate  (fscan_clkungate)
    );

    // Drop the spare column on the way out
    assign rdata = rdata_phys[rf_data_w-1:0];

endmodule

// File: hw/mem_pwr_seq.sv
// ------------------------------------------------
// Memory power-gate sequencer
// Orders enable chain and isolation from one request
// ------------------------------------------------

module mem_pwr_seq import list_sel_pkg::*; (
     input  logic rclk
    ,input  logic arst_n
    ,input  logic pwr_req
    ,input  logic pwr_enable_b_out
    ,output logic pwr_enable_b_in
    ,output logic pgcb_isol_en
    ,output logic pwr_ready
);

    pwr_state_e state_q;

    // ------------------------------------------------
    // State machine with registered outputs

    // Power-up order is supply first, then release isolation, then
    // report ready one cycle later
    // Power-down reverses it, isolation goes up together with the
    // ready drop and the supply is cut on the cycle after
    // A request change in mid-sequence waits for off or on
    always_ff @(posedge rclk or negedge arst_n) begin
        if (!arst_n) begin
            state_q         <= pwr_off;
            pwr_enable_b_in <= 1'b1;
            pgcb_isol_en    <= 1'b1;
            pwr_ready       <= 1'b0;
        end else begin
            case (state_q)
                // Gated and isolated, wait for a request
                pwr_off: begin
                    if (pwr_req) begin
                        pwr_enable_b_in <= 1'b0;
                        state_q         <= pwr_wake;
                    end
                end

                // Enable is rippling through the chain
                // Isolation may only drop once the acknowledge is back
                pwr_wake: begin
                    if (!pwr_enable_b_out) begin
                        pgcb_isol_en <= 1'b0;
                        state_q      <= pwr_on;
                    end
                end

                // Usable, ready follows the request
                pwr_on: begin
                    if (!pwr_req) begin
                        pwr_ready    <= 1'b0;
                        pgcb_isol_en <= 1'b1;
                        state_q      <= pwr_isolate;
                    end else begin
                        pwr_ready <= 1'b1;
                    end
                end

                // Outputs clamped, now cut the supply
                pwr_isolate: begin
                    pwr_enable_b_in <= 1'b1;
                    state_q         <= pwr_sleep;
                end

                // Wait for the chain to report the supply is off
                pwr_sleep: begin
                    if (pwr_enable_b_out) begin
                        state_q <= pwr_off;
                    end
                end

                // Unused codes fall back to the safe gated state
                default: begin
                    pwr_enable_b_in <= 1'b1;
                    pgcb_isol_en    <= 1'b1;
                    pwr_ready       <= 1'b0;
                    state_q         <= pwr_off;
                end
            endcase
        end
    end

endmodule

// File: hw/list_sel_mem_top.sv
// ------------------------------------------------
// List-selection memory subsystem top level
// Power sequencer plus the 4x35 register file
// ------------------------------------------------

module list_sel_mem_top import list_sel_pkg::*; (
     input  logic                 wclk
    ,input  logic                 rclk
    ,input  logic                 arst_n

    // Write port on wclk
    ,input  logic                 we
    ,input  logic [rf_addr_w-1:0] waddr
    ,input  logic [rf_data_w-1:0] wdata

    // Read port on rclk
    ,input  logic                 re
    ,input  logic [rf_addr_w-1:0] raddr
    ,output logic [rf_data_w-1:0] rdata

    // Power request and status
    ,input  logic                 pwr_req
    ,output logic                 pwr_ready

    // Scan controls
    ,input  logic                 fscan_rstbypen
    ,input  logic                 fscan_byprst_b
    ,input  logic                 fscan_clkungate
);

    // Power-gate handshake between sequencer and array
    logic pwr_enable_b_in;
    logic pwr_enable_b_out;
    logic pgcb_isol_en;

    // ------------------------------------------------
    // Power sequencer, runs on the read clock

    mem_pwr_seq u_pwr_seq (
         .rclk             (rclk)
        ,.arst_n           (arst_n)
        ,.pwr_req          (pwr_req)
        ,.pwr_enable_b_out (pwr_enable_b_out)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.pgcb_isol_en     (pgcb_isol_en)
        ,.pwr_ready        (pwr_ready)
    );

    // ------------------------------------------------
    // Register file

    list_sel_mem_rf_pg_4x35 u_rf (
         .wclk             (wclk)
        ,.arst_n           (arst_n)
        ,.we               (we)
        ,.waddr            (waddr)
        ,.wdata            (wdata)
        ,.rclk             (rclk)
        ,.re               (re)
        ,.raddr            (raddr)
        ,.rdata            (rdata)
        ,.pgcb_isol_en     (pgcb_isol_en)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.pwr_enable_b_out (pwr_enable_b_out)
        ,.fscan_byprst_b   (fscan_byprst_b)
        ,.fscan_clkungate  (fscan_clkungate)
        ,.fscan_rstbypen   (fscan_rstbypen)
    );

endmodule

// File: tests/list_sel_mem_sva.sv
// ------------------------------------------------
// Power and isolation assertions for the memory top
// ------------------------------------------------

module list_sel_mem_sva import list_sel_pkg::*; (
     input logic                 rclk
    ,input logic                 arst_n
    ,input logic                 pwr_ready
    ,input logic                 pgcb_isol_en
    ,input logic                 pwr_enable_b_out
    ,input logic                 fscan_rstbypen
    ,input logic [rf_data_w-1:0] rdata
);

    timeunit 1ns;
    timeprecision 1ps;

    // Number of rule failures seen over the run
    int sva_errors = 0;

    // Ready is only reported with the output unclamped
    a_ready_unisolated: assert property (
        @(posedge rclk) disable iff (!arst_n) pwr_ready |-> !pgcb_isol_en
    ) else begin
        $error("pwr_ready high while isolation is on");
        sva_errors++;
    end

    // Isolation may only be off once the enable chain acknowledges power
    // A scan reset bypass collapses the chain under a live sequencer
    a_isol_after_ack: assert property (
        @(posedge rclk) disable iff (!arst_n || fscan_rstbypen)
        !pgcb_isol_en |-> !pwr_enable_b_out
    ) else begin
        $error("isolation off while the array supply is not acknowledged");
        sva_errors++;
    end

    // The clamp drives zero regardless of the array state
    a_isol_clamps: assert property (
        @(posedge rclk) disable iff (!arst_n) pgcb_isol_en |-> (rdata == '0)
    ) else begin
        $error("rdata not zero while isolated");
        sva_errors++;
    end

endmodule

bind list_sel_mem_top list_sel_mem_sva u_sva (
     .rclk             (rclk)
    ,.arst_n           (arst_n)
    ,.pwr_ready        (pwr_ready)
    ,.pgcb_isol_en     (pgcb_isol_en)
    ,.pwr_enable_b_out (pwr_enable_b_out)
    ,.fscan_rstbypen   (fscan_rstbypen)
    ,.rdata            (rdata)
);

// File: tests/tb_list_sel_mem.sv
// ------------------------------------------------
// Testbench for the list-selection memory subsystem
// Table of operations checked against a reference model
// ------------------------------------------------

module tb_list_sel_mem import list_sel_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    typedef enum {
        op_write, op_read, op_hold, op_ungate, op_pwr_on, op_pwr_off, op_arst, op_scan
    } op_e;

    // One table row
    // The expected value is only compared when chk is set
    typedef struct {
        op_e                  op;
        logic [rf_addr_w-1:0] addr;
        logic [rf_data_w-1:0] data;
        logic                 byp_en;
        logic                 byp_rst_b;
        logic [rf_data_w-1:0] exp;
        logic                 chk;
    } row_t;

    localparam int ready_timeout = 4 * pwr_ack_dly + 10;

    logic wclk = 1'b0;
    logic rclk = 1'b0;
    logic arst_n, we, re, pwr_req, pwr_ready;
    logic fscan_rstbypen, fscan_byprst_b, fscan_clkungate;
    logic [rf_addr_w-1:0] waddr, raddr;
    logic [rf_data_w-1:0] wdata, rdata;

    integer seed;
    int     check_errors;
    int     timeout_errors;
    logic   timed_out;
    row_t   rows[$];

    // Reference model state
    // Stored words, their validity and the read register
    logic [rf_data_w-1:0] m_mem [rf_depth];
    logic                 m_valid [rf_depth];
    logic [rf_data_w-1:0] m_rd;
    logic                 m_rd_valid, m_powered, m_isolated, m_byp_held;

    always #10 wclk = ~wclk;
    always #10 rclk = ~rclk;

    list_sel_mem_top dut0 (
         .wclk (wclk), .rclk (rclk), .arst_n (arst_n)
        ,.we (we), .waddr (waddr), .wdata (wdata)
        ,.re (re), .raddr (raddr), .rdata (rdata)
        ,.pwr_req (pwr_req), .pwr_ready (pwr_ready)
        ,.fscan_rstbypen (fscan_rstbypen), .fscan_byprst_b (fscan_byprst_b)
        ,.fscan_clkungate (fscan_clkungate)
    );

    // ------------------------------------------------
    // Reference model

    // Power loss leaves every entry unknown
    task automatic forget_contents();
        for (int a = 0; a < rf_depth; a++) begin
            m_valid[a] = 1'b0;
        end
    endtask

    // A held scan reset keeps the read register at zero
    task automatic capture(input logic [rf_addr_w-1:0] addr);
        if (m_byp_held) begin
            m_rd       = '0;
            m_rd_valid = 1'b1;
        end else begin
            m_rd       = m_mem[addr];
            m_rd_valid = m_powered && m_valid[addr];
        end
    endtask

    task automatic add_row(input op_e op, input int addr, input logic byp_en,
                           input logic byp_rst_b);
        row_t        r;
        logic [63:0] rnd;
        rnd         = {$random(seed), $random(seed)};
        r.op        = op;
        r.addr      = addr[rf_addr_w-1:0];
        r.data      = rnd[rf_data_w-1:0];
        r.byp_en    = byp_en;
        r.byp_rst_b = byp_rst_b;
        case (op)
            op_write: begin
                // Writes only land while the enable chain reports power
                if (m_powered) begin
                    m_mem[r.addr]   = r.data;
                    m_valid[r.addr] = 1'b1;
                end
            end
            op_read, op_ungate: capture(r.addr);
            op_pwr_on: begin
                m_isolated = 1'b0;
                m_powered  = !m_byp_held;
            end
            op_pwr_off: begin
                m_isolated = 1'b1;
                m_powered  = 1'b0;
                forget_contents();
            end
            op_arst: begin
                m_isolated = 1'b1;
                m_powered  = 1'b0;
                m_rd       = '0;
                m_rd_valid = 1'b1;
                forget_contents();
            end
            op_scan: begin
                m_byp_held = byp_en && !byp_rst_b;
                if (m_byp_held) begin
                    m_powered = 1'b0;
                    forget_contents();
                end
                capture(r.addr);
            end
            default: ;
        endcase
        // Isolation clamps the output whatever the register holds
        r.exp = m_isolated ? '0 : m_rd;
        r.chk = (op != op_write) && (m_isolated || m_rd_valid);
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_row(op_pwr_on, 0, 0, 1);
        for (int a = 0; a < rf_depth; a++) begin
            add_row(op_write, a, 0, 1);
        end
        for (int a = rf_depth - 1; a >= 0; a--) begin
            add_row(op_read, a, 0, 1);
        end
        // Read register holds while raddr moves, then follows it under scan ungate
        add_row(op_read, 2, 0, 1);
        add_row(op_hold, 0, 0, 1);
        add_row(op_hold, 3, 0, 1);
        for (int a = 0; a < rf_depth; a++) begin
            add_row(op_ungate, a, 0, 1);
        end
        // Power down, a dropped write, then restore and rewrite
        add_row(op_pwr_off, 0, 0, 1);
        add_row(op_write, 1, 0, 1);
        add_row(op_read, 1, 0, 1);
        add_row(op_pwr_on, 0, 0, 1);
        for (int a = 0; a < rf_depth; a++) begin
            add_row(op_write, a, 0, 1);
        end
        for (int a = 0; a < rf_depth; a++) begin
            add_row(op_read, a, 0, 1);
        end
        // Second reset pulse, then the scan reset bypass
        add_row(op_arst, 0, 0, 1);
        add_row(op_pwr_on, 0, 0, 1);
        add_row(op_write, 2, 0, 1);
        add_row(op_read, 2, 0, 1);
        add_row(op_scan, 2, 1, 0);
        add_row(op_read, 1, 1, 0);
        add_row(op_pwr_off, 0, 1, 0);
        add_row(op_scan, 0, 0, 1);
    endtask

    // ------------------------------------------------
    // Stimulus and checks

    task automatic check_rdata(input logic [rf_data_w-1:0] exp);
        assert (rdata === exp) else begin
            $display("CHECK FAILED at %0t: rdata expected %h, got %h", $time, exp, rdata);
            check_errors++;
        end
    endtask

    task automatic wait_for_ready(input logic level);
        int n;
        n = 0;
        while (pwr_ready !== level && n < ready_timeout) begin
            @(negedge rclk);
            n++;
        end
        if (pwr_ready !== level) begin
            $display("Timeout at %0t: pwr_ready did not reach %0b within %0d rclk cycles",
                     $time, level, ready_timeout);
            timeout_errors++;
            timed_out = 1'b1;
        end
    endtask

    // Inputs change on the falling edge and rdata is sampled one cycle later
    task automatic apply_row(input row_t r);
        @(negedge rclk);
        we              = 1'b0;
        re              = 1'b0;
        fscan_clkungate = 1'b0;
        waddr           = r.addr;
        raddr           = r.addr;
        wdata           = r.data;
        case (r.op)
            op_write:   we = 1'b1;
            op_read:    re = 1'b1;
            op_ungate:  fscan_clkungate = 1'b1;
            op_pwr_on:  pwr_req = 1'b1;
            op_pwr_off: pwr_req = 1'b0;
            op_arst:    arst_n = 1'b0;
            op_scan: begin
                fscan_rstbypen = r.byp_en;
                fscan_byprst_b = r.byp_rst_b;
                re             = 1'b1;
            end
            default: ;
        endcase
        @(negedge rclk);
        case (r.op)
            op_pwr_on:  wait_for_ready(1'b1);
            op_pwr_off: wait_for_ready(1'b0);
            op_arst: begin
                repeat (2) @(negedge rclk);
                arst_n = 1'b1;
            end
            default: ;
        endcase
        if (r.chk && !timed_out) begin
            check_rdata(r.exp);
        end
    endtask

    initial begin
        seed            = 95176;
        arst_n          = 1'b0;
        we              = 1'b0;
        re              = 1'b0;
        pwr_req         = 1'b0;
        fscan_rstbypen  = 1'b0;
        fscan_byprst_b  = 1'b1;
        fscan_clkungate = 1'b0;
        waddr           = '0;
        raddr           = '0;
        wdata           = '0;
        check_errors    = 0;
        timeout_errors  = 0;
        timed_out       = 1'b0;
        // Model starts isolated and unpowered with a cleared read register
        m_rd            = '0;
        m_rd_valid      = 1'b1;
        m_isolated      = 1'b1;
        m_powered       = 1'b0;
        m_byp_held      = 1'b0;
        forget_contents();
        build_table();
        repeat (16) @(negedge rclk);
        arst_n = 1'b1;
        repeat (2) @(negedge rclk);
        assert (pwr_ready === 1'b0) else begin
            $display("CHECK FAILED at %0t: pwr_ready expected 0, got %b", $time, pwr_ready);
            check_errors++;
        end
        check_rdata('0);
        for (int i = 0; i < rows.size() && !timed_out; i++) begin
            apply_row(rows[i]);
        end
        repeat (2) @(negedge rclk);
        $display("Errors: %0d check, %0d timeout, %0d assertion",
                 check_errors, timeout_errors, dut0.u_sva.sva_errors);
        if (check_errors == 0 && timeout_errors == 0 && dut0.u_sva.sva_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: src.f
common/list_sel_pkg.sv
hw/mem_reset_sync_scan.sv
rf_4x36/rf_4x36_array.sv
rf_4x36/list_sel_mem_rf_pg_4x35.sv
hw/mem_pwr_seq.sv
hw/list_sel_mem_top.sv
tests/list_sel_mem_sva.sv
tests/tb_list_sel_mem.sv
